//--- source/lane_cfg_pkg.sv
// lane buffer sizing and status
package lane_cfg_pkg;

  localparam int IN_LANES   = 4;   // producer lanes per cycle
  localparam int OUT_LANES  = 4;   // consumer lanes per cycle
  localparam int FIFO_DEPTH = 16;  // keep a power of two, pointers wrap

  // fifo fill state seen by the consumer side
  typedef struct packed {
    logic [$clog2(FIFO_DEPTH):0] count;  // occupied entries, 0..FIFO_DEPTH
    logic                        full;
    logic                        empty;
  } fifo_status_t;

endpackage

//--- source/lane_types_pkg.sv
// lane payload and bus types
package lane_types_pkg;

  // one item as carried on a lane
  typedef struct packed {
    logic [3:0]  tag;
    logic [15:0] data;
  } item_t;

  // producer side, any subset of lanes may be valid
  typedef struct packed {
    logic  [lane_cfg_pkg::IN_LANES-1:0] valid;
    item_t [lane_cfg_pkg::IN_LANES-1:0] item;
  } push_bus_t;

  // consumer side, valids are always low-packed
  typedef struct packed {
    logic  [lane_cfg_pkg::OUT_LANES-1:0] valid;
    item_t [lane_cfg_pkg::OUT_LANES-1:0] item;
  } pop_bus_t;

endpackage

//--- source/lane_compactor.sv
// in-order lane compaction stage
`timescale 1ns/1ps

module lane_compactor #(
  parameter type T = logic [7:0],
  parameter int  M = 4
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      flush,
  input  lane_types_pkg::push_bus_t in_bus,
  output logic                      in_ready,
  output logic [M-1:0]              push,
  output T     [M-1:0]              push_data,
  input  logic                      drain
);

  logic [M-1:0] pack_mask;  // valid lanes moved to the low end
  T     [M-1:0] pack_data;
  logic [M-1:0] mask_q;
  T     [M-1:0] data_q;

  // walk the lanes in order, each valid one takes the next free slot
  always_comb begin
    int slot;
    slot      = 0;
    pack_mask = '0;
    pack_data = '0;
    for (int k = 0; k < M; k++) begin
      if (in_bus.valid[k]) begin
        pack_mask[slot] = 1'b1;
        pack_data[slot] = in_bus.item[k];
        slot++;
      end
    end
  end

  // empty register or one being drained can take a new word
  assign in_ready = !(|mask_q) || drain;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mask_q <= '0;
    end else if (flush) begin
      mask_q <= '0;  // drop held word
    end else if (in_ready) begin
      mask_q <= pack_mask;  // all zero when nothing offered
    end
  end

  always_ff @(posedge clk) begin
    if (in_ready && |pack_mask) data_q <= pack_data;
  end

  assign push      = drain ? mask_q : '0;  // held word leaves only when the fifo has room
  assign push_data = data_q;

endmodule

//--- source/multi_fifo.sv
// multi-push multi-pop sync fifo
`timescale 1ns/1ps

module multi_fifo #(
  parameter type T     = logic [7:0],
  parameter int  M     = 4,   // push lanes
  parameter int  N     = 4,   // pop lanes
  parameter int  DEPTH = 16
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        clear,
  input  logic [M-1:0]                push,         // low-packed
  input  T     [M-1:0]                datain,
  output logic [M-1:0]                almost_full,  // bit i set when free entries <= i
  input  logic [N-1:0]                pop,          // low-packed
  output T     [N-1:0]                dataout,      // oldest entry in lane 0
  output lane_cfg_pkg::fifo_status_t  status
);

  localparam int PW = $clog2(DEPTH);
  localparam int CW = PW + 1;

  T mem [DEPTH];

  logic [PW-1:0] wptr;
  logic [PW-1:0] rptr;
  logic [CW-1:0] count;
  logic [CW-1:0] push_cnt;
  logic [CW-1:0] pop_cnt;
  logic [CW-1:0] next_count;
  logic [PW-1:0] wr_idx [M];
  logic [PW-1:0] rd_idx [N];

  // number of set bits on each side
  always_comb begin
    push_cnt = '0;
    for (int j = 0; j < M; j++) begin
      push_cnt = push_cnt + CW'(push[j]);
    end
  end

  always_comb begin
    pop_cnt = '0;
    for (int j = 0; j < N; j++) begin
      pop_cnt = pop_cnt + CW'(pop[j]);
    end
  end

  assign next_count = count + push_cnt - pop_cnt;

  // slot addresses, wrap at DEPTH
  for (genvar j = 0; j < M; j++) begin : g_wr_idx
    assign wr_idx[j] = wptr + PW'(j);
  end

  for (genvar i = 0; i < N; i++) begin : g_rd_idx
    assign rd_idx[i] = rptr + PW'(i);
  end

  // pointers and fill count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else if (clear) begin
      wptr  <= '0;  // flush beats any push or pop
      rptr  <= '0;
      count <= '0;
    end else begin
      if (|push) wptr <= wptr + push_cnt[PW-1:0];
      if (|pop)  rptr <= rptr + pop_cnt[PW-1:0];
      if (|push || |pop) count <= next_count;
    end
  end

  // lane j lands only if j entries beyond it are still free
  always_ff @(posedge clk) begin
    if (!clear) begin
      for (int j = 0; j < M; j++) begin
        if (push[j] && !almost_full[j]) mem[wr_idx[j]] <= datain[j];
      end
    end
  end

  // almost_full[0] doubles as full
  for (genvar i = 0; i < M; i++) begin : g_almost_full
    assign almost_full[i] = (count + CW'(i)) >= CW'(DEPTH);
  end

  // read window, entries past count are stale
  for (genvar i = 0; i < N; i++) begin : g_dataout
    assign dataout[i] = mem[rd_idx[i]];
  end

  assign status.count = count;
  assign status.full  = (count == CW'(DEPTH));
  assign status.empty = (count == '0);

endmodule

//--- source/burst_pop_ctrl.sv
// consumer side pop control
`timescale 1ns/1ps

module burst_pop_ctrl #(
  parameter int N = 4
) (
  input  lane_cfg_pkg::fifo_status_t      status,
  input  logic [$clog2(N+1)-1:0]          out_take,  // lanes the consumer accepts
  input  lane_types_pkg::item_t [N-1:0]   window,
  output lane_types_pkg::pop_bus_t        out_bus,
  output logic [N-1:0]                    pop
);

  import lane_cfg_pkg::*;

  localparam int CW = $clog2(FIFO_DEPTH) + 1;
  localparam int TW = $clog2(N + 1);

  logic [N-1:0] lane_vld;   // thermometer of available entries
  logic [N-1:0] take_mask;  // thermometer of requested lanes

  for (genvar i = 0; i < N; i++) begin : g_lane
    assign lane_vld[i]  = status.count > CW'(i);
    assign take_mask[i] = out_take > TW'(i);
  end

  // and of two thermometers is the smaller one
  assign pop = lane_vld & take_mask;

  assign out_bus.valid = lane_vld;
  assign out_bus.item  = window;  // lanes above count carry stale data

endmodule

//--- source/lane_buffer_top.sv
// lane ordering buffer top
`timescale 1ns/1ps

module lane_buffer_top (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  lane_types_pkg::push_bus_t                   in_bus,
  output logic                                        in_ready,
  output lane_types_pkg::pop_bus_t                    out_bus,
  input  logic [$clog2(lane_cfg_pkg::OUT_LANES+1)-1:0] out_take,
  input  logic                                        flush,
  output lane_cfg_pkg::fifo_status_t                  status
);

  import lane_cfg_pkg::*;
  import lane_types_pkg::*;

  logic  [IN_LANES-1:0]  push;         // compacted push mask
  item_t [IN_LANES-1:0]  push_data;
  logic  [IN_LANES-1:0]  almost_full;
  logic  [OUT_LANES-1:0] pop;
  item_t [OUT_LANES-1:0] window;       // oldest entries first

  lane_compactor #(
    .T (item_t),
    .M (IN_LANES)
  ) i_lane_compactor (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .in_bus    (in_bus),
    .in_ready  (in_ready),
    .push      (push),
    .push_data (push_data),
    .drain     (!almost_full[IN_LANES-1])  // room for a whole word
  );

  multi_fifo #(
    .T     (item_t),
    .M     (IN_LANES),
    .N     (OUT_LANES),
    .DEPTH (FIFO_DEPTH)
  ) i_multi_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear       (flush),
    .push        (push),
    .datain      (push_data),
    .almost_full (almost_full),
    .pop         (pop),
    .dataout     (window),
    .status      (status)
  );

  burst_pop_ctrl #(
    .N (OUT_LANES)
  ) i_burst_pop_ctrl (
    .status   (status),
    .out_take (out_take),
    .window   (window),
    .out_bus  (out_bus),
    .pop      (pop)
  );

endmodule

//--- tests/lane_buffer_assert.sv
// fifo occupancy and push mask checks
`timescale 1ns/1ps

module lane_buffer_assert #(
  parameter int M     = 4,
  parameter int N     = 4,
  parameter int DEPTH = 16
) (
  input logic                   clk,
  input logic                   rst_n,
  input logic [M-1:0]           push,
  input logic [N-1:0]           pop,
  input logic [$clog2(DEPTH):0] count
);

  int unsigned fail_cnt = 0;  // assertion failures so far

  // compactor only drains into free entries
  a_no_overflow : assert property (
    @(posedge clk) disable iff (!rst_n) $countones(push) <= DEPTH - int'(count)
  ) else begin
    $error("push of %0d lanes with %0d entries free", $countones(push), DEPTH - int'(count));
    fail_cnt++;
  end

  a_no_underflow : assert property (
    @(posedge clk) disable iff (!rst_n) $countones(pop) <= int'(count)
  ) else begin
    $error("pop of %0d lanes with %0d entries stored", $countones(pop), count);
    fail_cnt++;
  end

  // compacted mask is a thermometer code
  a_push_packed : assert property (
    @(posedge clk) disable iff (!rst_n) (push & (push + 1'b1)) == '0
  ) else begin
    $error("push mask %b is not packed to the low lanes", push);
    fail_cnt++;
  end

endmodule

bind multi_fifo lane_buffer_assert #(
  .M     (M),
  .N     (N),
  .DEPTH (DEPTH)
) i_fifo_assert (
  .clk   (clk),
  .rst_n (rst_n),
  .push  (push),
  .pop   (pop),
  .count (count)
);

//--- tests/lane_buffer_tb.sv
// lane buffer testbench
`timescale 1ns/1ps

module lane_buffer_tb;

  import lane_cfg_pkg::*;
  import lane_types_pkg::*;

  localparam int TAKE_W     = $clog2(OUT_LANES + 1);
  localparam int CW         = $clog2(FIFO_DEPTH) + 1;
  localparam int WAIT_LIMIT = 100;  // cycles for any wait loop

  logic              clk;
  logic              rst_n;
  push_bus_t         in_bus;
  logic              in_ready;
  pop_bus_t          out_bus;
  logic [TAKE_W-1:0] out_take;
  logic              flush;
  fifo_status_t      status;

  item_t       model_q[$];  // fifo contents, oldest first
  item_t       hold_q[$];   // compactor register
  logic        ready_seen;  // in_ready at the last edge
  logic [15:0] lfsr_state     = 16'd77;
  string       test_name      = "reset";
  int unsigned value_errors   = 0;
  int unsigned timeout_errors = 0;

  lane_buffer_top i_lane_buffer_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_bus   (in_bus),
    .in_ready (in_ready),
    .out_bus  (out_bus),
    .out_take (out_take),
    .flush    (flush),
    .status   (status)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // galois lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) return (s >> 1) ^ 16'hB400;
    return s >> 1;
  endfunction

  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // oldest entries shown low-packed, unused lanes zero
  function automatic pop_bus_t expected_bus();
    pop_bus_t b;
    b = '0;
    for (int i = 0; i < OUT_LANES; i++) begin
      if (i < model_q.size()) begin
        b.valid[i] = 1'b1;
        b.item[i]  = model_q[i];
      end
    end
    return b;
  endfunction

  function automatic fifo_status_t expected_status();
    fifo_status_t s;
    s.count = CW'(model_q.size());
    s.full  = (model_q.size() == FIFO_DEPTH);
    s.empty = (model_q.size() == 0);
    return s;
  endfunction

  function automatic logic expected_ready();
    return (hold_q.size() == 0) || (FIFO_DEPTH - model_q.size() >= IN_LANES);
  endfunction

  // state after the coming edge, from the inputs now applied
  function automatic void advance_model();
    int npop;
    bit drain;
    bit ready;
    drain = (FIFO_DEPTH - model_q.size()) >= IN_LANES;
    ready = (hold_q.size() == 0) || drain;
    if (flush) begin
      model_q.delete();
      hold_q.delete();
    end else begin
      npop = int'(out_take);
      if (npop > OUT_LANES) npop = OUT_LANES;
      if (npop > model_q.size()) npop = model_q.size();
      repeat (npop) void'(model_q.pop_front());
      if (drain) begin
        while (hold_q.size() > 0) model_q.push_back(hold_q.pop_front());
      end
      if (ready) begin
        for (int k = 0; k < IN_LANES; k++) begin
          if (in_bus.valid[k]) hold_q.push_back(in_bus.item[k]);
        end
      end
    end
  endfunction

  task automatic check_bus(input string name, input pop_bus_t exp, input pop_bus_t act);
    pop_bus_t seen;
    seen = act;
    for (int i = 0; i < OUT_LANES; i++) begin
      if (!exp.valid[i]) seen.item[i] = '0;  // stale lanes carry no meaning
    end
    if (seen !== exp) begin
      value_errors++;
      $display("Fail %s: out_bus expected %h, actual %h", name, exp, seen);
    end
  endtask

  task automatic check_status(input string name, input fifo_status_t exp,
                              input fifo_status_t act);
    if (act !== exp) begin
      value_errors++;
      $display("Fail %s: status count/full/empty expected %0d/%b/%b, actual %0d/%b/%b",
               name, exp.count, exp.full, exp.empty, act.count, act.full, act.empty);
    end
  endtask

  task automatic check_ready(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("Fail %s: in_ready expected %b, actual %b", name, exp, act);
    end
  endtask

  // compare at the falling edge, then step the model
  always @(negedge clk) begin
    ready_seen = in_ready;
    if (!rst_n) begin
      model_q.delete();
      hold_q.delete();
    end else begin
      check_bus(test_name, expected_bus(), out_bus);
      check_status(test_name, expected_status(), status);
      check_ready(test_name, expected_ready(), in_ready);
      advance_model();
    end
  end

  task automatic end_run();
    int unsigned asrt_errors;
    asrt_errors = i_lane_buffer_top.i_multi_fifo.i_fifo_assert.fail_cnt;
    $display("errors: %0d value, %0d timeout, %0d assertion", value_errors,
             timeout_errors, asrt_errors);
    if (value_errors == 0 && timeout_errors == 0 && asrt_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  task automatic note_timeout(input string what);
    timeout_errors++;
    $display("Timeout in %s, %s", test_name, what);
  endtask

  // one producer and consumer cycle, word held until accepted
  task automatic step_cycle(input bit offer, input bit all_lanes,
                            input logic [TAKE_W-1:0] take, input bit do_flush);
    bit          word_done;
    logic [31:0] r;
    @(posedge clk);
    #2;
    word_done = (in_bus.valid == '0) || ready_seen || flush;
    if (do_flush) begin
      in_bus.valid = '0;
    end else if (word_done) begin
      in_bus = '0;
      if (offer) begin
        r            = draw_bits(IN_LANES);
        in_bus.valid = all_lanes ? '1 : r[IN_LANES-1:0];
        for (int k = 0; k < IN_LANES; k++) begin
          r                   = draw_bits(4);
          in_bus.item[k].tag  = r[3:0];
          r                   = draw_bits(16);
          in_bus.item[k].data = r[15:0];
        end
      end
    end
    out_take = take;
    flush    = do_flush;
  endtask

  task automatic run_traffic(input int cycles, input bit random_take);
    logic [31:0]       r;
    logic [TAKE_W-1:0] take;
    for (int c = 0; c < cycles; c++) begin
      take = TAKE_W'(OUT_LANES);
      if (random_take) begin
        r    = draw_bits(TAKE_W);
        take = r[TAKE_W-1:0];  // may exceed OUT_LANES
      end
      step_cycle(1'b1, 1'b0, take, 1'b0);
    end
  endtask

  task automatic drain_all();
    int n;
    n = 0;
    while ((in_bus.valid != '0 || !status.empty || model_q.size() != 0 ||
            hold_q.size() != 0) && n < WAIT_LIMIT) begin
      step_cycle(1'b0, 1'b0, TAKE_W'(OUT_LANES), 1'b0);
      n++;
    end
    if (in_bus.valid != '0 || !status.empty || model_q.size() != 0 || hold_q.size() != 0)
      note_timeout("buffer did not drain with every lane taken");
  endtask

  initial begin
    int           n;
    fifo_status_t exp_st;
    rst_n    = 1'b0;
    in_bus   = '0;
    out_take = '0;
    flush    = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    step_cycle(1'b0, 1'b0, '0, 1'b0);
    exp_st       = '0;
    exp_st.empty = 1'b1;
    check_status(test_name, exp_st, status);
    check_bus(test_name, '0, out_bus);
    check_ready(test_name, 1'b1, in_ready);

    test_name = "sparse_order";
    run_traffic(60, 1'b0);
    drain_all();

    test_name = "partial_take";
    run_traffic(80, 1'b1);
    drain_all();

    // consumer stalled until back-pressure shows
    test_name = "fill";
    n = 0;
    while (in_ready && n < WAIT_LIMIT) begin
      step_cycle(1'b1, 1'b1, '0, 1'b0);
      n++;
    end
    if (in_ready) note_timeout("in_ready never dropped with out_take held at 0");
    repeat (8) step_cycle(1'b1, 1'b1, '0, 1'b0);
    drain_all();

    test_name = "flush";
    run_traffic(20, 1'b1);
    step_cycle(1'b0, 1'b0, '0, 1'b1);
    run_traffic(30, 1'b1);
    drain_all();

    test_name = "random";
    run_traffic(300, 1'b1);
    drain_all();
    end_run();
  end

endmodule

//--- sources.f
source/lane_cfg_pkg.sv
source/lane_types_pkg.sv
source/lane_compactor.sv
source/multi_fifo.sv
source/burst_pop_ctrl.sv
source/lane_buffer_top.sv
tests/lane_buffer_assert.sv
tests/lane_buffer_tb.sv

//--- Makefile
# Verilator build and run of the lane buffer testbench
TOP := lane_buffer_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
